// File: dv/icache_props.sv
// protocol properties for the instruction cache core
// BIU strobe stability, aligned requests, parcel hold under stall

`timescale 1ns/10ps
`default_nettype none

module icache_props
  import icache_pkg::*;
(
  input wire logic     clk,
  input wire logic     rstn,
  input wire logic     if_stall,
  input wire logic     bu_cacheflush,
  input wire logic     if_stall_nxt_pc,
  input wire logic     if_parcel_valid,
  input wire word_t    if_parcel,
  input wire addr_t    if_parcel_pc,
  input wire biu_req_t biu_req,
  input wire biu_rsp_t biu_rsp
);

  // strobe and address held until acknowledged
  stb_held: assert property (@(posedge clk) disable iff (!rstn)
    biu_req.stb && !biu_rsp.stb_ack |=> biu_req.stb && $stable(biu_req.adri))
    else $error("biu strobe dropped or address changed before ack");

  stb_aligned: assert property (@(posedge clk) disable iff (!rstn)
    biu_req.stb |-> biu_req.adri[3:0] == 4'h0)
    else $error("biu request address not block aligned");

  // no next pc taken while a fill is requested
  fill_stalls: assert property (@(posedge clk) disable iff (!rstn)
    biu_req.stb |-> if_stall_nxt_pc)
    else $error("next pc not stalled during a fill request");

  // cpu back-pressure keeps the parcel
  parcel_hold: assert property (@(posedge clk) disable iff (!rstn)
    if_stall && if_parcel_valid && !bu_cacheflush |=>
      if_parcel_valid && $stable(if_parcel) && $stable(if_parcel_pc))
    else $error("parcel changed while stalled");

endmodule

bind icache_core icache_props u_props (
  .clk             (clk),
  .rstn            (rstn),
  .if_stall        (if_stall),
  .bu_cacheflush   (bu_cacheflush),
  .if_stall_nxt_pc (if_stall_nxt_pc),
  .if_parcel_valid (if_parcel_valid),
  .if_parcel       (if_parcel),
  .if_parcel_pc    (if_parcel_pc),
  .biu_req         (biu_req),
  .biu_rsp         (biu_rsp)
);

`default_nettype wire

// File: dv/icache_stimulus.txt
// cmd addr parcel miss, cmd 0 fetch, 1 flush, f end
// parcel is the address xor c0de0000
0 00001000 c0de1000 1
0 0000100c c0de100c 0
0 00001004 c0de1004 0
// same set, second way
0 00001080 c0de1080 1
0 00001008 c0de1008 0
0 00001084 c0de1084 0
0 0000108c c0de108c 0
0 00002010 c0de2010 1
0 00002014 c0de2014 0
1 00000000 00000000 0
// flushed blocks miss again
0 00001000 c0de1000 1
0 00001080 c0de1080 1
0 0000100c c0de100c 0
0 00001088 c0de1088 0
f 00000000 00000000 0

// File: dv/tb_clkgen.sv
// clock and reset generator for the instruction cache testbench
// 100 ns clock, reset held low for 16 cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rstn
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    rstn = 1'b0;
    repeat (16) @(posedge clk);
    #1 rstn = 1'b1;  // release just after the edge
  end

endmodule

`default_nettype wire

// File: dv/tb_icache.sv
// testbench for the instruction cache core
// BIU memory model with random beat gaps, fetch and flush commands
// read from a stimulus file, parcels and misses checked per fetch

`timescale 1ns/10ps
`default_nettype none

module tb_icache;
  import icache_pkg::*;

  localparam int STIM_WORDS = 128;
  localparam int TIMEOUT    = 400;  // cycles per wait
  localparam int SETS       = 8;    // flush walks one set per cycle

  logic     clk;
  logic     rstn;
  addr_t    if_nxt_pc;
  logic     if_stall;
  logic     bu_cacheflush;
  logic     if_stall_nxt_pc;
  word_t    if_parcel;
  addr_t    if_parcel_pc;
  logic     if_parcel_valid;
  biu_req_t biu_req;
  biu_rsp_t biu_rsp;

  logic [31:0] stim [STIM_WORDS];
  logic [31:0] lfsr;

  tb_clkgen u_clkgen (
    .clk  (clk),
    .rstn (rstn)
  );

  icache_core #(.CACHE_SIZE(256), .BLOCK_SIZE(16), .WAYS(2)) dut0 (
    .clk             (clk),
    .rstn            (rstn),
    .if_nxt_pc       (if_nxt_pc),
    .if_stall        (if_stall),
    .bu_cacheflush   (bu_cacheflush),
    .if_stall_nxt_pc (if_stall_nxt_pc),
    .if_parcel       (if_parcel),
    .if_parcel_pc    (if_parcel_pc),
    .if_parcel_valid (if_parcel_valid),
    .biu_req         (biu_req),
    .biu_rsp         (biu_rsp)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("Test failures found");
    $fatal(1);
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  //////////////////////////////
  // BIU memory model
  //////////////////////////////
  initial
  begin
    addr_t adr;
    logic  b0, b1;
    lfsr    = 32'h68a1afe7;
    biu_rsp = '0;
    forever
    begin
      @(negedge clk);
      if (rstn && biu_req.stb)
      begin
        adr = biu_req.adri;
        repeat (2) @(posedge clk);  // ack latency
        #1 biu_rsp.stb_ack = 1'b1;
        @(posedge clk);
        #1 biu_rsp.stb_ack = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
          b0 = rand_bit();
          b1 = rand_bit();
          repeat (int'({b1, b0})) @(posedge clk);  // idle gap
          #1;
          biu_rsp.rack = 1'b1;
          biu_rsp.adro = adr + 32'(4 * i);
          biu_rsp.dat  = (adr + 32'(4 * i)) ^ 32'hc0de0000;
          @(posedge clk);
          #1 biu_rsp.rack = 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // commands
  //////////////////////////////
  task automatic send_flush();
    @(posedge clk);
    #1 bu_cacheflush = 1'b1;
    @(posedge clk);
    #1 bu_cacheflush = 1'b0;
  endtask

  task automatic fetch_and_check(input addr_t adr, input word_t exp_dat, input logic exp_miss);
    int    cnt;
    int    bursts;
    logic  prev_stb;
    @(posedge clk);
    #1;
    if_nxt_pc = adr;
    if_stall  = 1'b0;
    cnt = 0;
    forever
    begin
      @(negedge clk);
      if (!if_stall_nxt_pc)
        break;
      cnt++;
      if (cnt > TIMEOUT)
        report_timeout("fetch address never accepted");
    end
    @(posedge clk);  // accepted here
    #1 if_stall = 1'b1;
    cnt      = 0;
    bursts   = 0;
    prev_stb = 1'b0;
    forever
    begin
      @(negedge clk);
      if (biu_req.stb && !prev_stb)
      begin
        bursts++;
        check_value("strobe latency", 32'(cnt), 32'd1);  // first fill cycle
        check_value("burst address", biu_req.adri, adr & 32'hffff_fff0);
        check_value("burst type", 32'(biu_req.btype), 32'(HBURST_INCR4));
      end
      prev_stb = biu_req.stb;
      if (if_parcel_valid)
        break;
      cnt++;
      if (cnt > TIMEOUT)
        report_timeout("no parcel returned for fetch");
    end
    check_value("miss bursts", 32'(bursts), 32'(exp_miss));
    if (!exp_miss)
      check_value("hit latency", 32'(cnt), 32'd0);  // valid one cycle after accept
    check_value("parcel pc", if_parcel_pc, adr);
    check_value("parcel", if_parcel, exp_dat);
    repeat (4)  // outputs hold while stalled
    begin
      @(negedge clk);
      check_value("held valid", 32'(if_parcel_valid), 32'd1);
      check_value("held parcel pc", if_parcel_pc, adr);
      check_value("held parcel", if_parcel, exp_dat);
    end
  endtask

  initial
  begin
    int i;
    int cnt;
    if_nxt_pc     = '0;
    if_stall      = 1'b1;
    bu_cacheflush = 1'b0;
    $readmemh("dv/icache_stimulus.txt", stim);

    cnt = 0;
    while (rstn !== 1'b1)
    begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT)
        report_timeout("reset never released");
    end

    for (int k = 0; k < 10; k++)  // covers the 8 set flush
    begin
      @(negedge clk);
      if (k < SETS)
        check_value("stall during flush", 32'(if_stall_nxt_pc), 32'd1);
      check_value("valid after reset", 32'(if_parcel_valid), 32'd0);
      check_value("stb after reset", 32'(biu_req.stb), 32'd0);
    end

    i = 0;
    while (i + 3 < STIM_WORDS && stim[i] != 32'hf)
    begin
      if (stim[i] == 32'h1)
        send_flush();
      else
        fetch_and_check(stim[i+1], stim[i+2], stim[i+3][0]);
      i += 4;
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/icache_core.sv
// instruction cache core of the fetch unit
// registers the fetch pc, reads all ways in parallel and returns
// one 32 bit parcel per hit, one cycle after the pc is accepted
// misses are filled from the BIU by the controller

`timescale 1ns/10ps
`default_nettype none

module icache_core
  import icache_pkg::*;
#(
  parameter  int    CACHE_SIZE   = 256,
  parameter  int    BLOCK_SIZE   = 16,
  parameter  int    WAYS         = 2,
  parameter  addr_t PC_INIT      = 32'h0000_0200,
  localparam int    SETS         = CACHE_SIZE / BLOCK_SIZE / WAYS,
  localparam int    IDX_BITS     = $clog2(SETS),
  localparam int    BLK_OFF_BITS = $clog2(BLOCK_SIZE),
  localparam int    BURST_LEN    = BLOCK_SIZE / (XLEN/8),
  localparam int    BEAT_BITS    = $clog2(BURST_LEN),
  localparam int    TAG_BITS     = XLEN - IDX_BITS - BLK_OFF_BITS
)
(
  input  logic     clk,
  input  logic     rstn,
  input  addr_t    if_nxt_pc,
  input  logic     if_stall,
  input  logic     bu_cacheflush,
  output logic     if_stall_nxt_pc,
  output word_t    if_parcel,
  output addr_t    if_parcel_pc,
  output logic     if_parcel_valid,
  output biu_req_t biu_req,
  input  biu_rsp_t biu_rsp
);

  localparam int WORD_LSB = $clog2(XLEN/8);  // pc[1:0] ignored

  addr_t               pc;
  addr_t               rd_pc;
  logic                pc_valid;
  logic                accept;
  logic                hit;
  word_t               hit_dat;
  logic                flushing;
  logic [IDX_BITS-1:0] flush_idx;
  logic                tag_we, dat_we;

  assign accept = ~if_stall & ~if_stall_nxt_pc;

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      pc       <= PC_INIT;
      pc_valid <= 1'b0;
    end
    else if (accept)
    begin
      pc       <= if_nxt_pc;
      pc_valid <= 1'b1;
    end
  end

  // read ahead with the next pc, else keep reading pc
  assign rd_pc = accept ? if_nxt_pc : pc;

  icache_ctrl #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .WAYS(WAYS)) u_ctrl (
    .clk             (clk),
    .rstn            (rstn),
    .pc              (pc),
    .pc_valid        (pc_valid),
    .hit             (hit),
    .bu_cacheflush   (bu_cacheflush),
    .biu_rsp         (biu_rsp),
    .biu_req         (biu_req),
    .flushing        (flushing),
    .flush_idx       (flush_idx),
    .tag_we          (tag_we),
    .dat_we          (dat_we),
    .if_stall_nxt_pc (if_stall_nxt_pc)
  );

  icache_ways #(.CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .WAYS(WAYS)) u_ways (
    .clk        (clk),
    .rstn       (rstn),
    .rd_idx     (rd_pc[BLK_OFF_BITS +: IDX_BITS]),
    .rd_word    (rd_pc[WORD_LSB +: BEAT_BITS]),
    .lookup_tag (pc[XLEN-1 -: TAG_BITS]),
    .tag_we     (tag_we),
    .dat_we     (dat_we),
    .flushing   (flushing),
    .flush_idx  (flush_idx),
    .fill_adr   (biu_rsp.adro),
    .fill_dat   (biu_rsp.dat),
    .hit        (hit),
    .hit_dat    (hit_dat)
  );

  // parcel outputs follow pc, so they hold while stalled
  assign if_parcel       = hit_dat;
  assign if_parcel_pc    = pc;
  assign if_parcel_valid = pc_valid & hit & ~if_stall_nxt_pc;  // armed, current hit

endmodule

`default_nettype wire

// File: hdl/icache_ctrl.sv
// instruction cache controller
// FLUSH walks all sets and clears the valid bits
// ARMED checks the lookup of pc and starts a fill on a miss
// FILL requests one incrementing burst from the BIU and writes
// each beat, the tag goes in with the last beat

`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
#(
  parameter  int CACHE_SIZE   = 256,
  parameter  int BLOCK_SIZE   = 16,
  parameter  int WAYS         = 2,
  localparam int SETS         = CACHE_SIZE / BLOCK_SIZE / WAYS,
  localparam int IDX_BITS     = $clog2(SETS),
  localparam int BLK_OFF_BITS = $clog2(BLOCK_SIZE),
  localparam int BURST_LEN    = BLOCK_SIZE / (XLEN/8),
  localparam int BEAT_BITS    = $clog2(BURST_LEN)
)
(
  input  logic                clk,
  input  logic                rstn,
  input  addr_t               pc,
  input  logic                pc_valid,
  input  logic                hit,
  input  logic                bu_cacheflush,
  input  biu_rsp_t            biu_rsp,
  output biu_req_t            biu_req,
  output logic                flushing,
  output logic [IDX_BITS-1:0] flush_idx,
  output logic                tag_we,
  output logic                dat_we,
  output logic                if_stall_nxt_pc
);

  localparam logic [2:0] BTYPE = (BURST_LEN == 16) ? HBURST_INCR16 :
                                 (BURST_LEN == 8)  ? HBURST_INCR8  :
                                                     HBURST_INCR4;

  ctrl_state_t          state, nxt_state;
  logic [IDX_BITS-1:0]  set_cnt;
  logic [BEAT_BITS-1:0] beat_cnt;
  logic                 stb_done;    // request acknowledged
  logic                 flush_pend;  // flush seen during a fill
  logic                 rd_ok;       // memory outputs are current
  logic                 flush_req;
  logic                 miss;
  logic                 last_beat;
  logic                 flush_last;

  assign flush_req  = bu_cacheflush | flush_pend;
  assign flush_last = (state == FLUSH) & (set_cnt == IDX_BITS'(SETS - 1));
  assign last_beat  = (state == FILL) & biu_rsp.rack &
                      (beat_cnt == BEAT_BITS'(BURST_LEN - 1));

  // rd_ok is only ever set while ARMED
  assign miss = rd_ok & pc_valid & ~hit;

  //////////////////////////////
  // state machine
  //////////////////////////////
  always_comb
  begin
    nxt_state = state;
    case (state)
      FLUSH:
      begin
        if (flush_last)
        begin
          nxt_state = ARMED;
        end
      end
      ARMED:
      begin
        if (flush_req)
        begin
          nxt_state = FLUSH;
        end
        else if (miss)
        begin
          nxt_state = FILL;
        end
      end
      FILL:
      begin
        if (last_beat)
        begin
          nxt_state = flush_req ? FLUSH : ARMED;  // held flush taken here
        end
      end
      default: nxt_state = FLUSH;
    endcase
  end

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      state      <= FLUSH;
      flush_pend <= 1'b0;
      rd_ok      <= 1'b0;
    end
    else
    begin
      state      <= nxt_state;
      flush_pend <= flush_req & (state != FLUSH) & (nxt_state != FLUSH);
      // the read in the first ARMED cycle may predate the last write
      rd_ok      <= (state == ARMED) & (nxt_state == ARMED);
    end
  end

  //////////////////////////////
  // set and beat counters
  //////////////////////////////
  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      set_cnt  <= '0;
      beat_cnt <= '0;
      stb_done <= 1'b0;
    end
    else
    begin
      if (state != FLUSH || flush_last)
      begin
        set_cnt <= '0;
      end
      else
      begin
        set_cnt <= set_cnt + 1'b1;
      end

      if (state != FILL)
      begin
        beat_cnt <= '0;
        stb_done <= 1'b0;
      end
      else
      begin
        if (biu_rsp.rack)
        begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        if (biu_req.stb && biu_rsp.stb_ack)
        begin
          stb_done <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////
  always_comb
  begin
    biu_req.stb   = (state == FILL) & ~stb_done;
    biu_req.adri  = {pc[XLEN-1:BLK_OFF_BITS], {BLK_OFF_BITS{1'b0}}};
    biu_req.btype = BTYPE;
  end

  assign flushing  = (state == FLUSH);
  assign flush_idx = set_cnt;
  assign dat_we    = (state == FILL) & biu_rsp.rack;
  assign tag_we    = flushing | last_beat;

  // next pc accepted only on a current lookup without a miss
  assign if_stall_nxt_pc = ~rd_ok | (pc_valid & ~hit);

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
// instruction cache shared definitions
// bus widths, BIU request/response structs, controller states
// and the AHB burst codes used for cache line fills

`default_nettype none

package icache_pkg;

  localparam int XLEN = 32;  // one word, data and address

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;

  //////////////////////////////
  // AHB burst types
  //////////////////////////////
  localparam logic [2:0] HBURST_INCR4  = 3'b011;
  localparam logic [2:0] HBURST_INCR8  = 3'b101;
  localparam logic [2:0] HBURST_INCR16 = 3'b111;

  //////////////////////////////
  // BIU interface
  //////////////////////////////

  // cache to BIU
  typedef struct packed {
    logic       stb;    // held until stb_ack
    addr_t      adri;   // block aligned start
    logic [2:0] btype;
  } biu_req_t;

  // BIU to cache
  typedef struct packed {
    logic  stb_ack;
    logic  rack;  // one per data beat
    addr_t adro;  // beat address
    word_t dat;
  } biu_rsp_t;

  // fill controller states
  typedef enum logic [2:0] {
    FLUSH = 3'b000,
    ARMED = 3'b010,
    FILL  = 3'b100
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/icache_ram.sv
// simple dual port memory for the instruction cache
// one synchronous read port, one write port
// entry type is a parameter so tags and data words share it
// read during write to the same address returns the old entry

`timescale 1ns/10ps
`default_nettype none

module icache_ram #(
  parameter int  ABITS = 4,
  parameter type T     = logic [31:0]
)
(
  input  logic             clk,
  input  logic [ABITS-1:0] raddr,
  input  logic [ABITS-1:0] waddr,
  input  logic             we,
  input  T                 din,
  output T                 dout
);

  localparam int DEPTH = 2**ABITS;

  T mem [DEPTH];

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[waddr] <= din;
    end
    dout <= mem[raddr];  // old contents on collision
  end

endmodule

`default_nettype wire

// File: hdl/icache_ways.sv
// instruction cache way array
// tag and data memories per way, tag compare and hit data mux
// victim way selection, lowest invalid way first, else a
// 20 bit pseudo random register
// write enables go to the victim on a fill, to all ways on a flush

`timescale 1ns/10ps
`default_nettype none

module icache_ways
  import icache_pkg::*;
#(
  parameter  int CACHE_SIZE   = 256,
  parameter  int BLOCK_SIZE   = 16,
  parameter  int WAYS         = 2,
  localparam int SETS         = CACHE_SIZE / BLOCK_SIZE / WAYS,
  localparam int IDX_BITS     = $clog2(SETS),
  localparam int BLK_OFF_BITS = $clog2(BLOCK_SIZE),
  localparam int BURST_LEN    = BLOCK_SIZE / (XLEN/8),
  localparam int BEAT_BITS    = $clog2(BURST_LEN),
  localparam int TAG_BITS     = XLEN - IDX_BITS - BLK_OFF_BITS
)
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic [IDX_BITS-1:0]  rd_idx,
  input  logic [BEAT_BITS-1:0] rd_word,
  input  logic [TAG_BITS-1:0]  lookup_tag,
  input  logic                 tag_we,
  input  logic                 dat_we,
  input  logic                 flushing,
  input  logic [IDX_BITS-1:0]  flush_idx,
  input  addr_t                fill_adr,
  input  word_t                fill_dat,
  output logic                 hit,
  output word_t                hit_dat
);

  localparam int WORD_LSB = $clog2(XLEN/8);
  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  tag_entry_t          tag_q [WAYS];
  tag_entry_t          tag_din;
  word_t               dat_q [WAYS];
  logic [IDX_BITS-1:0] tag_waddr;
  logic [WAYS-1:0]     way_hit;
  logic [WAYS-1:0]     victim_nxt, victim_q, victim_sel;
  logic [19:0]         way_random;
  logic [WAY_BITS-1:0] rnd_way;
  logic                fill_act;

  assign tag_din.valid = ~flushing;  // flush clears, fill sets
  assign tag_din.tag   = fill_adr[XLEN-1 -: TAG_BITS];
  assign tag_waddr     = flushing ? flush_idx : fill_adr[BLK_OFF_BITS +: IDX_BITS];

  //////////////////////////////
  // memories and tag compare
  //////////////////////////////
  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    icache_ram #(.ABITS(IDX_BITS), .T(tag_entry_t)) u_tag_ram (
      .clk   (clk),
      .raddr (rd_idx),
      .waddr (tag_waddr),
      .we    (tag_we & (flushing | victim_sel[w])),
      .din   (tag_din),
      .dout  (tag_q[w])
    );

    icache_ram #(.ABITS(IDX_BITS + BEAT_BITS), .T(word_t)) u_dat_ram (
      .clk   (clk),
      .raddr ({rd_idx, rd_word}),
      .waddr (fill_adr[WORD_LSB +: IDX_BITS + BEAT_BITS]),
      .we    (dat_we & victim_sel[w]),
      .din   (fill_dat),
      .dout  (dat_q[w])
    );

    assign way_hit[w] = tag_q[w].valid & (tag_q[w].tag == lookup_tag);
  end

  assign hit = |way_hit;

  always_comb
  begin
    hit_dat = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      hit_dat = hit_dat | (dat_q[w] & {XLEN{way_hit[w]}});  // and-or mux
    end
  end

  //////////////////////////////
  // victim selection
  //////////////////////////////
  assign rnd_way = way_random[WAY_BITS-1:0];

  always_comb
  begin
    victim_nxt = '0;
    victim_nxt[int'(rnd_way) % WAYS] = 1'b1;
    for (int w = WAYS-1; w >= 0; w--)
    begin
      if (!tag_q[w].valid)  // lowest invalid wins
      begin
        victim_nxt = '0;
        victim_nxt[w] = 1'b1;
      end
    end
  end

  // first beat picks the way, later beats reuse it
  assign victim_sel = fill_act ? victim_q : victim_nxt;

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      fill_act   <= 1'b0;
      way_random <= '0;
    end
    else
    begin
      fill_act <= (fill_act | dat_we) & ~tag_we;  // ends with the tag write
      if (!fill_act)
      begin
        way_random <= {way_random[18:0], way_random[19] ~^ way_random[16]};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (dat_we && !fill_act)
    begin
      victim_q <= victim_nxt;
    end
  end

endmodule

`default_nettype wire

// File: icache_core.f
hdl/icache_pkg.sv
hdl/icache_ram.sv
hdl/icache_ways.sv
hdl/icache_ctrl.sv
hdl/icache_core.sv
dv/tb_clkgen.sv
dv/icache_props.sv
dv/tb_icache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f icache_core.f \
  --top-module tb_icache \
  -o sim_icache

# the simulator exits non-zero on $fatal, the search below decides
out=$(./obj_dir/sim_icache) || true
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
else
  echo "simulation did not report a pass"
  exit 1
fi
